// ==== logic/hb_wb_pkg.sv ====
package hb_wb_pkg;

	// device address map
	// 3000_0000 up to 307f_ffff is RAM
	// 3080_00xx is the HyperRAM register space
	// 3081_00xx holds the timing CSRs
	localparam logic [31:0] BASE_ADDR = 32'h3000_0000;
	localparam logic [31:0] RAM_ADDR_MASK = 32'hff80_0000;
	localparam logic [31:0] REG_CSR_ADDR_MASK = 32'hffff_0000;
	localparam logic [31:0] REG_BASE = BASE_ADDR + 32'h0080_0000;
	localparam logic [31:0] CSR_BASE = BASE_ADDR + 32'h0081_0000;

	// CSR offsets inside the CSR window
	localparam logic [31:0] CSR_LATENCY_OFFSET = 32'd0;
	localparam logic [31:0] CSR_TPRE_TPOST_OFFSET = 32'd4;
	localparam logic [31:0] CSR_TCSH_OFFSET = 32'd8;
	localparam logic [31:0] CSR_TRMAX_OFFSET = 32'd12;
	localparam logic [31:0] CSR_STATUS_OFFSET = 32'd16;

	// timing defaults after reset
	localparam logic [5:0] LATENCY_DEFAULT = 6'h36;
	localparam logic [7:0] TPRE_TPOST_DEFAULT = 8'h44;
	localparam logic [3:0] TCSH_DEFAULT = 4'h4;
	localparam logic [4:0] TRMAX_DEFAULT = 5'h14;

	typedef enum logic [2:0] {
		CSR_LATENCY,
		CSR_TPRE_TPOST,
		CSR_TCSH,
		CSR_TRMAX,
		CSR_STATUS,
		CSR_NONE
	} csr_idx_e;

	// classic wishbone request and response
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// hits already qualified by cyc and stb
	typedef struct packed {
		logic ram_hit;
		logic reg_hit;
		logic csr_hit;
		csr_idx_e csr_idx;
		logic [31:0] sub_addr;
	} dec_t;

	typedef struct packed {
		logic fixed_latency;
		logic double_latency;
		logic [3:0] tacc;
		logic [3:0] tpre;
		logic [3:0] tpost;
		logic [3:0] tcsh;
		logic [4:0] trmax;
	} hb_timing_t;

	// controller side
	// addr counts 16-bit words
	typedef struct packed {
		logic valid;
		logic wren;
		logic regspace;
		logic [31:0] addr;
		logic [3:0] sel;
		logic [31:0] data;
	} hb_req_t;

	typedef struct packed {
		logic ready;
		logic [31:0] data;
		logic read_timeout;
	} hb_rsp_t;

endpackage

// ==== logic/hb_addr_decode.sv ====
`timescale 1ns/10ps

module hb_addr_decode
	import hb_wb_pkg::*;
(
	input wb_req_t req_i,
	output dec_t dec_o
);

	logic bus_active;
	logic ram_match;
	logic reg_match;
	logic csr_match;

	assign bus_active = req_i.cyc && req_i.stb;

	// window compare on the raw address
	assign ram_match = (req_i.adr & RAM_ADDR_MASK) == BASE_ADDR;
	assign reg_match = (req_i.adr & REG_CSR_ADDR_MASK) == REG_BASE;
	assign csr_match = (req_i.adr & REG_CSR_ADDR_MASK) == CSR_BASE;

	always_comb begin
		dec_o.ram_hit = bus_active && ram_match;
		dec_o.reg_hit = bus_active && reg_match;
		dec_o.csr_hit = bus_active && csr_match;

		// strip the window base
		if (dec_o.ram_hit) begin
			dec_o.sub_addr = req_i.adr & ~RAM_ADDR_MASK;
		end else if (dec_o.reg_hit || dec_o.csr_hit) begin
			dec_o.sub_addr = req_i.adr & ~REG_CSR_ADDR_MASK;
		end else begin
			dec_o.sub_addr = 32'h0000_0000;
		end

		// only exact word offsets select a CSR
		dec_o.csr_idx = CSR_NONE;
		if (dec_o.csr_hit) begin
			case (dec_o.sub_addr)
				CSR_LATENCY_OFFSET: begin
					dec_o.csr_idx = CSR_LATENCY;
				end
				CSR_TPRE_TPOST_OFFSET: begin
					dec_o.csr_idx = CSR_TPRE_TPOST;
				end
				CSR_TCSH_OFFSET: begin
					dec_o.csr_idx = CSR_TCSH;
				end
				CSR_TRMAX_OFFSET: begin
					dec_o.csr_idx = CSR_TRMAX;
				end
				CSR_STATUS_OFFSET: begin
					dec_o.csr_idx = CSR_STATUS;
				end
				default: begin
					dec_o.csr_idx = CSR_NONE;
				end
			endcase
		end

		// the three windows must never overlap
		assert ($onehot0({dec_o.ram_hit, dec_o.reg_hit, dec_o.csr_hit}))
			else $error("address decode hit more than one window");
	end

endmodule

// ==== logic/hb_csr_bank.sv ====
`timescale 1ns/10ps

module hb_csr_bank
	import hb_wb_pkg::*;
(
	input logic wb_clk_i,
	input logic rst_i,
	input wb_req_t req_i,
	input dec_t dec_i,
	input logic read_timeout_i,
	output hb_timing_t timing_o,
	output logic [31:0] csr_rdata_o,
	output logic csr_ack_o
);

	// fixed_latency, double_latency, tacc
	logic [5:0] latency_q;
	// tpre, tpost
	logic [7:0] tpre_tpost_q;
	logic [3:0] tcsh_q;
	logic [4:0] trmax_q;

	logic csr_hit_prev_q;
	logic csr_ack_q;
	logic csr_wr;

	// write only in the first cycle of the access
	// the strobe stays high until the ack is seen
	assign csr_wr = dec_i.csr_hit && !csr_hit_prev_q && req_i.we && req_i.sel[0];

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			latency_q <= LATENCY_DEFAULT;
			tpre_tpost_q <= TPRE_TPOST_DEFAULT;
			tcsh_q <= TCSH_DEFAULT;
			trmax_q <= TRMAX_DEFAULT;
			csr_hit_prev_q <= 1'b0;
			csr_ack_q <= 1'b0;
		end else begin
			csr_hit_prev_q <= dec_i.csr_hit;
			csr_ack_q <= dec_i.csr_idx != CSR_NONE;
			if (csr_wr) begin
				case (dec_i.csr_idx)
					CSR_LATENCY: begin
						latency_q <= req_i.dat[5:0];
					end
					CSR_TPRE_TPOST: begin
						tpre_tpost_q <= req_i.dat[7:0];
					end
					CSR_TCSH: begin
						tcsh_q <= req_i.dat[3:0];
					end
					CSR_TRMAX: begin
						trmax_q <= req_i.dat[4:0];
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign timing_o.fixed_latency = latency_q[5];
	assign timing_o.double_latency = latency_q[4];
	assign timing_o.tacc = latency_q[3:0];
	assign timing_o.tpre = tpre_tpost_q[7:4];
	assign timing_o.tpost = tpre_tpost_q[3:0];
	assign timing_o.tcsh = tcsh_q;
	assign timing_o.trmax = trmax_q;

	// zero extended readback
	always_comb begin
		case (dec_i.csr_idx)
			CSR_LATENCY: csr_rdata_o = {26'd0, latency_q};
			CSR_TPRE_TPOST: csr_rdata_o = {24'd0, tpre_tpost_q};
			CSR_TCSH: csr_rdata_o = {28'd0, tcsh_q};
			CSR_TRMAX: csr_rdata_o = {27'd0, trmax_q};
			CSR_STATUS: csr_rdata_o = {31'd0, read_timeout_i};
			default: csr_rdata_o = 32'h0000_0000;
		endcase
	end

	assign csr_ack_o = csr_ack_q;

	// timing registers move only after a qualified write
	a_csr_write_only: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		!$stable({latency_q, tpre_tpost_q, tcsh_q, trmax_q}) |->
			($past(csr_wr) || $past(rst_i)))
		else $error("timing CSR changed without a write");

endmodule

// ==== logic/hb_wb_response.sv ====
`timescale 1ns/10ps

module hb_wb_response
	import hb_wb_pkg::*;
(
	input logic wb_clk_i,
	input logic rst_i,
	input wb_req_t req_i,
	input dec_t dec_i,
	input logic [31:0] csr_rdata_i,
	input logic csr_ack_i,
	input hb_rsp_t hb_rsp_i,
	output hb_req_t hb_req_o,
	output wb_rsp_t rsp_o
);

	logic hb_hit;
	logic hb_hit_prev_q;

	assign hb_hit = dec_i.ram_hit || dec_i.reg_hit;

	// a ready seen in the first strobe cycle belongs to the previous access
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			hb_hit_prev_q <= 1'b0;
		end else begin
			hb_hit_prev_q <= hb_hit;
		end
	end

	// controller request follows the strobe as a level
	always_comb begin
		hb_req_o.valid = hb_hit;
		hb_req_o.wren = req_i.we;
		hb_req_o.regspace = dec_i.reg_hit;
		// byte address to 16-bit word address
		hb_req_o.addr = {1'b0, dec_i.sub_addr[31:1]};
		hb_req_o.sel = req_i.sel;
		hb_req_o.data = req_i.dat;
	end

	// read data
	always_comb begin
		if (req_i.we) begin
			rsp_o.dat = 32'h0000_0000;
		end else if (dec_i.csr_hit) begin
			rsp_o.dat = csr_rdata_i;
		end else if (hb_hit) begin
			rsp_o.dat = hb_rsp_i.data;
		end else begin
			rsp_o.dat = 32'h0000_0000;
		end
	end

	// csr ack is registered, so it drops with the hit
	always_comb begin
		if (hb_hit) begin
			rsp_o.ack = hb_hit_prev_q && hb_rsp_i.ready;
		end else begin
			rsp_o.ack = csr_ack_i && dec_i.csr_hit;
		end
	end

	a_ack_needs_strobe: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		rsp_o.ack |-> (req_i.cyc && req_i.stb))
		else $error("ack without cyc and stb");

	// csr ack never comes in the first strobe cycle
	a_csr_ack_late: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(rsp_o.ack && dec_i.csr_hit) |-> $past(dec_i.csr_hit))
		else $error("csr ack in the first cycle");

endmodule

// ==== logic/wb_hyperram_top.sv ====
`timescale 1ns/10ps

module wb_hyperram_top
	import hb_wb_pkg::*;
(
	input logic wb_clk_i,
	input logic rst_i,

	// wishbone slave
	input wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o,

	// hyperram controller
	output hb_req_t hb_req_o,
	input hb_rsp_t hb_rsp_i,
	output hb_timing_t hb_timing_o
);

	dec_t dec;
	logic [31:0] csr_rdata;
	logic csr_ack;

	// combinational window decode
	hb_addr_decode hb_addr_decode_i (
		.req_i(wb_req_i),
		.dec_o(dec)
	);

	// timing CSRs
	// the status bit comes from the controller
	hb_csr_bank hb_csr_bank_i (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.req_i(wb_req_i),
		.dec_i(dec),
		.read_timeout_i(hb_rsp_i.read_timeout),
		.timing_o(hb_timing_o),
		.csr_rdata_o(csr_rdata),
		.csr_ack_o(csr_ack)
	);

	// controller request, read mux and ack
	hb_wb_response hb_wb_response_i (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.req_i(wb_req_i),
		.dec_i(dec),
		.csr_rdata_i(csr_rdata),
		.csr_ack_i(csr_ack),
		.hb_rsp_i(hb_rsp_i),
		.hb_req_o(hb_req_o),
		.rsp_o(wb_rsp_o)
	);

endmodule

// ==== verification/tb_ctrl_responder.sv ====
`timescale 1ns/10ps

module tb_ctrl_responder
	import hb_wb_pkg::*;
(
	input logic wb_clk_i,
	input logic rst_i,
	input hb_req_t hb_req_i,
	input logic read_timeout_i,
	output hb_rsp_t hb_rsp_o
);

	// sparse byte memories keyed by window byte address
	logic [7:0] ram_mem [logic [31:0]];
	logic [7:0] reg_mem [logic [31:0]];

	logic ready_q = 1'b0;
	logic [31:0] data_q = 32'h0000_0000;
	logic busy = 1'b0;
	logic done = 1'b0;
	int wait_cnt = 0;

	assign hb_rsp_o = '{ready: ready_q, data: data_q, read_timeout: read_timeout_i};

	always begin : respond
		hb_req_t req;
		logic [31:0] key;
		logic [31:0] word;
		logic fire;
		@(posedge wb_clk_i);
		req = hb_req_i;
		fire = 1'b0;
		word = 32'h0000_0000;
		if (rst_i) begin
			busy = 1'b0;
			done = 1'b0;
		end else if (ready_q) begin
			// one ready pulse, then wait for valid to fall
			done = 1'b1;
		end else if (done) begin
			if (!req.valid) begin
				done = 1'b0;
			end
		end else if (req.valid) begin
			if (!busy) begin
				busy = 1'b1;
				wait_cnt = $urandom_range(0, 3);
			end else begin
				wait_cnt = wait_cnt - 1;
			end
			fire = (wait_cnt == 0);
		end
		if (fire) begin
			busy = 1'b0;
			for (int b = 0; b < 4; b++) begin
				// word address back to bytes
				key = {req.addr[30:0], 1'b0} + 32'(b);
				if (req.wren && req.sel[b]) begin
					if (req.regspace) begin
						reg_mem[key] = req.data[8*b +: 8];
					end else begin
						ram_mem[key] = req.data[8*b +: 8];
					end
				end else if (!req.wren) begin
					if (req.regspace && reg_mem.exists(key)) begin
						word[8*b +: 8] = reg_mem[key];
					end else if (!req.regspace && ram_mem.exists(key)) begin
						word[8*b +: 8] = ram_mem[key];
					end
				end
			end
		end
		#1;
		ready_q = fire;
		if (fire) begin
			data_q = word;
		end
	end

endmodule

// ==== verification/tb_wb_hyperram.sv ====
`timescale 1ns/10ps

module tb_wb_hyperram
	import hb_wb_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int N_CSR_WR = 24;
	localparam int N_MEM = 80;
	localparam int N_ACKED = 5 + 2 * N_CSR_WR + 2 + 2 + N_MEM;
	localparam int N_SILENT = 5;
	localparam int NO_ACK_WAIT = 20;
	// idle edge, strobe cycle, up to 4 ready cycles, drop
	localparam int WORST_CYCLES = 8;
	localparam int WATCHDOG_NS =
		(N_ACKED * WORST_CYCLES + N_SILENT * (NO_ACK_WAIT + 2) + 20) * CLK_PERIOD;

	logic wb_clk_i;
	logic rst_i;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	hb_req_t hb_req;
	hb_rsp_t hb_rsp;
	hb_timing_t hb_timing;
	logic read_timeout;

	// reference state
	logic [5:0] latency_ref;
	logic [7:0] tpre_tpost_ref;
	logic [3:0] tcsh_ref;
	logic [4:0] trmax_ref;
	logic [7:0] ram_ref [logic [31:0]];
	logic [7:0] reg_ref [logic [31:0]];
	int acks = 0;

	wb_hyperram_top wb_hyperram_top_i (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.hb_req_o(hb_req),
		.hb_rsp_i(hb_rsp),
		.hb_timing_o(hb_timing)
	);

	tb_ctrl_responder tb_ctrl_responder_i (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.hb_req_i(hb_req),
		.read_timeout_i(read_timeout),
		.hb_rsp_o(hb_rsp)
	);

	initial wb_clk_i = 1'b0;
	always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic in_ram(input logic [31:0] adr);
		return (adr & 32'hff80_0000) == 32'h3000_0000;
	endfunction

	function automatic logic in_reg(input logic [31:0] adr);
		return (adr & 32'hffff_0000) == 32'h3080_0000;
	endfunction

	function automatic logic in_csr(input logic [31:0] adr);
		return (adr & 32'hffff_0000) == 32'h3081_0000;
	endfunction

	function automatic logic [31:0] window_offset(input logic [31:0] adr);
		return in_ram(adr) ? (adr & 32'h007f_ffff) : (adr & 32'h0000_ffff);
	endfunction

	// expected read word for any mapped address
	function automatic logic [31:0] ref_read(input logic [31:0] adr);
		logic [31:0] off;
		logic [31:0] key;
		logic [31:0] word;
		off = window_offset(adr);
		word = 32'h0000_0000;
		if (in_csr(adr)) begin
			case (off)
				32'd0: word = {26'd0, latency_ref};
				32'd4: word = {24'd0, tpre_tpost_ref};
				32'd8: word = {28'd0, tcsh_ref};
				32'd12: word = {27'd0, trmax_ref};
				32'd16: word = {31'd0, read_timeout};
				default: word = 32'h0000_0000;
			endcase
		end else begin
			for (int b = 0; b < 4; b++) begin
				key = off + 32'(b);
				if (in_ram(adr) && ram_ref.exists(key)) begin
					word[8*b +: 8] = ram_ref[key];
				end else if (in_reg(adr) && reg_ref.exists(key)) begin
					word[8*b +: 8] = reg_ref[key];
				end
			end
		end
		return word;
	endfunction

	task automatic record_write(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [31:0] off;
		logic [31:0] key;
		off = window_offset(adr);
		if (in_csr(adr)) begin
			// only byte lane 0 carries the CSR fields
			if (sel[0]) begin
				case (off)
					32'd0: latency_ref = dat[5:0];
					32'd4: tpre_tpost_ref = dat[7:0];
					32'd8: tcsh_ref = dat[3:0];
					32'd12: trmax_ref = dat[4:0];
					default: ;
				endcase
			end
		end else begin
			for (int b = 0; b < 4; b++) begin
				key = off + 32'(b);
				if (sel[b] && in_ram(adr)) begin
					ram_ref[key] = dat[8*b +: 8];
				end else if (sel[b]) begin
					reg_ref[key] = dat[8*b +: 8];
				end
			end
		end
	endtask

	function automatic hb_timing_t expected_timing();
		hb_timing_t t;
		t.fixed_latency = latency_ref[5];
		t.double_latency = latency_ref[4];
		t.tacc = latency_ref[3:0];
		t.tpre = tpre_tpost_ref[7:4];
		t.tpost = tpre_tpost_ref[3:0];
		t.tcsh = tcsh_ref;
		t.trmax = trmax_ref;
		return t;
	endfunction

	// one classic cycle held until ack or the no-ack limit
	task automatic wb_access(input logic [31:0] adr, input logic we, input logic [3:0] sel,
			input logic [31:0] dat, input logic expect_ack);
		int edges;
		@(posedge wb_clk_i);
		#1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.sel = sel;
		wb_req.adr = adr;
		wb_req.dat = dat;
		@(posedge wb_clk_i);
		edges = 1;
		while (!wb_rsp.ack && (expect_ack || edges < NO_ACK_WAIT)) begin
			@(posedge wb_clk_i);
			edges++;
		end
		if (expect_ack && in_csr(adr)) begin
			assert (edges == 2)
				else abort_run($sformatf("FAILED at %0t: CSR ack after %0d edges at %h",
					$time, edges, adr));
		end else if (expect_ack) begin
			assert (edges >= 2)
				else abort_run($sformatf("FAILED at %0t: ack in first cycle at %h", $time, adr));
		end else begin
			assert (!wb_rsp.ack)
				else abort_run($sformatf("FAILED at %0t: unexpected ack at %h", $time, adr));
		end
		#1;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	always @(posedge wb_clk_i) begin : compare
		logic exp_valid;
		logic [31:0] off;
		logic [31:0] exp_dat;
		if (!rst_i) begin
			exp_valid = wb_req.cyc && wb_req.stb && (in_ram(wb_req.adr) || in_reg(wb_req.adr));
			off = window_offset(wb_req.adr);
			assert (!wb_rsp.ack || (wb_req.cyc && wb_req.stb))
				else abort_run($sformatf("FAILED at %0t: ack without cyc and stb", $time));
			assert (hb_req.valid == exp_valid)
				else abort_run($sformatf("FAILED at %0t: controller valid %b, expected %b",
					$time, hb_req.valid, exp_valid));
			if (exp_valid) begin
				assert (hb_req.addr == {1'b0, off[31:1]} && hb_req.regspace == in_reg(wb_req.adr)
						&& hb_req.wren == wb_req.we && hb_req.sel == wb_req.sel
						&& hb_req.data == wb_req.dat)
					else abort_run($sformatf("FAILED at %0t: controller request addr %h for %h",
						$time, hb_req.addr, wb_req.adr));
			end
			if (wb_rsp.ack) begin
				acks++;
				if (wb_req.we) begin
					record_write(wb_req.adr, wb_req.sel, wb_req.dat);
				end else begin
					exp_dat = ref_read(wb_req.adr);
					assert (wb_rsp.dat == exp_dat)
						else abort_run($sformatf("FAILED at %0t: read %h at %h, expected %h",
							$time, wb_rsp.dat, wb_req.adr, exp_dat));
				end
			end
			assert (hb_timing == expected_timing())
				else abort_run($sformatf("FAILED at %0t: timing %h, expected %h",
					$time, hb_timing, expected_timing()));
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		abort_run("watchdog expired because a bus access never completed");
	end

	initial begin : stimulus
		logic [31:0] adr;
		void'($urandom(43780));
		rst_i = 1'b1;
		wb_req = '0;
		read_timeout = 1'b0;
		latency_ref = 6'h36;
		tpre_tpost_ref = 8'h44;
		tcsh_ref = 4'h4;
		trmax_ref = 5'h14;
		repeat (2) @(posedge wb_clk_i);
		#1;
		rst_i = 1'b0;

		// defaults of all five CSRs
		for (int i = 0; i < 5; i++) begin
			wb_access(32'h3081_0000 + 32'(4 * i), 1'b0, 4'hf, 32'h0, 1'b1);
		end

		// random CSR writes with a read back of each
		for (int i = 0; i < N_CSR_WR; i++) begin
			adr = 32'h3081_0000 + 4 * $urandom_range(0, 4);
			wb_access(adr, 1'b1, 4'($urandom_range(0, 15)), $urandom(), 1'b1);
			wb_access(adr, 1'b0, 4'hf, 32'h0, 1'b1);
		end
		wb_access(32'h3081_0004, 1'b1, 4'he, 32'hffff_ffff, 1'b1);
		wb_access(32'h3081_0004, 1'b0, 4'hf, 32'h0, 1'b1);

		// status follows the controller timeout level
		read_timeout = 1'b1;
		wb_access(32'h3081_0010, 1'b0, 4'hf, 32'h0, 1'b1);
		read_timeout = 1'b0;
		wb_access(32'h3081_0010, 1'b0, 4'hf, 32'h0, 1'b1);

		// RAM and register window traffic over a small address pool
		for (int i = 0; i < N_MEM; i++) begin
			if ($urandom_range(0, 1) == 1) begin
				adr = 32'h3000_0000 | ($urandom_range(0, 3) << 21) | ($urandom_range(0, 7) << 2);
			end else begin
				adr = 32'h3080_0000 | ($urandom_range(0, 15) << 2);
			end
			wb_access(adr, 1'($urandom_range(0, 1)), 4'($urandom_range(0, 15)), $urandom(), 1'b1);
		end

		// unmapped addresses stay silent
		wb_access(32'h2fff_fffc, 1'b0, 4'hf, 32'h0, 1'b0);
		wb_access(32'h3082_0000, 1'b1, 4'hf, 32'h1234_5678, 1'b0);
		wb_access(32'h4000_0000, 1'b0, 4'hf, 32'h0, 1'b0);
		wb_access(32'h3081_0014, 1'b1, 4'hf, 32'h0000_00ff, 1'b0);
		wb_access(32'h3081_0002, 1'b0, 4'hf, 32'h0, 1'b0);

		@(posedge wb_clk_i);
		#1;
		assert (acks == N_ACKED)
			else abort_run($sformatf("FAILED at %0t: %0d acks, expected %0d",
				$time, acks, N_ACKED));
		$display("sim passed");
		$finish;
	end

endmodule

// ==== src.f ====
logic/hb_wb_pkg.sv
logic/hb_addr_decode.sv
logic/hb_csr_bank.sv
logic/hb_wb_response.sv
logic/wb_hyperram_top.sv
verification/tb_ctrl_responder.sv
verification/tb_wb_hyperram.sv

// ==== Makefile ====
VERILATOR := verilator
TOP := tb_wb_hyperram
FILELIST := src.f
VFLAGS := --binary --timing --assert -j 0
BUILD_DIR := obj_dir

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
